//--- source/mem_op_pkg.sv
package mem_op_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OP_W       = 4;

    // Codes carried on op_i through both memory stages.
    localparam logic [OP_W-1:0] OP_NONE  = 4'd0;
    localparam logic [OP_W-1:0] OP_LD_B  = 4'd1;
    localparam logic [OP_W-1:0] OP_LD_BU = 4'd2;
    localparam logic [OP_W-1:0] OP_LD_H  = 4'd3;
    localparam logic [OP_W-1:0] OP_LD_HU = 4'd4;
    localparam logic [OP_W-1:0] OP_LD_W  = 4'd5;
    localparam logic [OP_W-1:0] OP_ST_B  = 4'd6;
    localparam logic [OP_W-1:0] OP_ST_H  = 4'd7;
    localparam logic [OP_W-1:0] OP_ST_W  = 4'd8;

    // Lane 0 is the byte or half at the lowest address of the word.
    typedef union packed {
        logic [XLEN/8-1:0][7:0]   byte_lane;
        logic [XLEN/16-1:0][15:0] half_lane;
    } mem_word_u;

    function automatic logic op_is_load(input logic [OP_W-1:0] op);
        return op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W};
    endfunction

    function automatic logic op_is_store(input logic [OP_W-1:0] op);
        return op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    endfunction

endpackage

//--- source/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // Depth of the data RAM in words.
    localparam int RAM_WORDS = 256;

    // Width of the word index taken from the byte address.
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

    // Cycles from the cycle a read is issued to the cycle data_ok is high.
    localparam int LOAD_LATENCY = 2;

endpackage

//--- source/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic valid_i,
    input  logic flush_i,
    input  logic s1_valid_i,
    input  logic s1_load_pending_i,
    input  logic data_ok_i,
    output logic ready_o,
    output logic s1_en_o,
    output logic s1_clr_o,
    output logic s2_en_o,
    output logic s2_clr_o
);

    logic accepted_q;
    logic rd_outstanding_q;
    logic rd_issue;
    logic stall;

    // The address stage issues its read in the first cycle after it takes a load.
    assign rd_issue = accepted_q & s1_valid_i & s1_load_pending_i;

    // A read left behind by a flush keeps the pipe stalled until its data_ok drains.
    assign stall = (s1_load_pending_i | rd_outstanding_q) & ~data_ok_i;

    assign ready_o = ~stall;

    // An operation presented together with flush is kept, since it is not yet in flight.
    assign s1_en_o  = ~stall;
    assign s1_clr_o = flush_i & stall;

    assign s2_en_o  = s1_valid_i & ~stall;
    assign s2_clr_o = flush_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            accepted_q <= 1'b0;
        end else begin
            accepted_q <= s1_en_o & valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_outstanding_q <= 1'b0;
        end else if (data_ok_i) begin
            rd_outstanding_q <= 1'b0;
        end else if (rd_issue) begin
            rd_outstanding_q <= 1'b1;
        end
    end

endmodule

//--- source/mem_addr_stage.sv
`timescale 1ns/1ps

module mem_addr_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                en_i,
    input  logic                                clr_i,
    input  logic                                valid_i,
    input  logic [mem_op_pkg::OP_W-1:0]         op_i,
    input  logic [mem_op_pkg::XLEN-1:0]         addr_i,
    input  logic [mem_op_pkg::XLEN-1:0]         wdata_i,
    input  logic [mem_op_pkg::REG_ADDR_W-1:0]   waddr_i,
    input  logic                                wreg_i,
    output logic                                s1_valid_o,
    output logic [mem_op_pkg::OP_W-1:0]         s1_op_o,
    output logic [mem_op_pkg::XLEN-1:0]         s1_addr_o,
    output logic [mem_op_pkg::XLEN-1:0]         s1_wdata_o,
    output logic [mem_op_pkg::REG_ADDR_W-1:0]   s1_waddr_o,
    output logic                                s1_wreg_o,
    output logic                                s1_excp_o,
    output logic                                s1_load_pending_o,
    output logic                                ram_re_o,
    output logic                                ram_we_o,
    output logic [mem_op_pkg::XLEN/8-1:0]       ram_be_o,
    output logic [mem_op_pkg::XLEN-1:0]         ram_addr_o,
    output logic [mem_op_pkg::XLEN-1:0]         ram_wdata_o
);
    import mem_op_pkg::*;

    logic                  valid_q;
    logic                  fresh_q;
    logic [OP_W-1:0]       op_q;
    logic [XLEN-1:0]       addr_q;
    logic [XLEN-1:0]       wdata_q;
    logic [REG_ADDR_W-1:0] waddr_q;
    logic                  wreg_q;
    logic                  misaligned;
    logic                  access_ok;
    mem_word_u             st_word;

    // fresh_q marks the first cycle of an operation, so the RAM sees each request once.
    always_ff @(posedge clk) begin
        if (rst || clr_i) begin
            valid_q <= 1'b0;
            fresh_q <= 1'b0;
        end else begin
            fresh_q <= en_i & valid_i;
            if (en_i) begin
                valid_q <= valid_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            op_q    <= op_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            waddr_q <= waddr_i;
            wreg_q  <= wreg_i;
        end
    end

    always_comb begin
        case (op_q)
            OP_LD_H, OP_LD_HU, OP_ST_H: misaligned = addr_q[0];
            OP_LD_W, OP_ST_W:           misaligned = |addr_q[1:0];
            default:                    misaligned = 1'b0;
        endcase
    end

    assign access_ok = valid_q & ~misaligned;

    // Store data is copied into every lane and the byte enables pick the target lanes.
    always_comb begin
        st_word.byte_lane = wdata_q;
        ram_be_o          = '0;
        case (op_q)
            OP_ST_B: begin
                for (int i = 0; i < XLEN/8; i++) begin
                    st_word.byte_lane[i] = wdata_q[7:0];
                end
                ram_be_o[addr_q[1:0]] = 1'b1;
            end
            OP_ST_H: begin
                for (int i = 0; i < XLEN/16; i++) begin
                    st_word.half_lane[i] = wdata_q[15:0];
                end
                ram_be_o[{addr_q[1], 1'b0} +: 2] = 2'b11;
            end
            OP_ST_W: ram_be_o = '1;
            default: ram_be_o = '0;
        endcase
    end

    assign s1_load_pending_o = access_ok & op_is_load(op_q);

    assign ram_re_o    = fresh_q & s1_load_pending_o;
    assign ram_we_o    = fresh_q & access_ok & op_is_store(op_q);
    assign ram_addr_o  = addr_q;
    assign ram_wdata_o = st_word;

    assign s1_valid_o = valid_q;
    assign s1_op_o    = op_q;
    assign s1_addr_o  = addr_q;
    assign s1_wdata_o = wdata_q;
    assign s1_waddr_o = waddr_q;
    assign s1_wreg_o  = wreg_q;
    assign s1_excp_o  = valid_q & misaligned;

endmodule

//--- source/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            re_i,
    input  logic                            we_i,
    input  logic [mem_op_pkg::XLEN/8-1:0]   be_i,
    input  logic [mem_op_pkg::XLEN-1:0]     addr_i,
    input  logic [mem_op_pkg::XLEN-1:0]     wdata_i,
    output logic [mem_op_pkg::XLEN-1:0]     rdata_o,
    output logic                            data_ok_o
);
    import mem_op_pkg::*;
    import mem_cfg_pkg::*;

    logic [XLEN/8-1:0][7:0]  mem [RAM_WORDS];
    logic [RAM_ADDR_W-1:0]   word_idx;
    logic [LOAD_LATENCY-1:0] ok_pipe;
    logic [XLEN-1:0]         data_pipe [LOAD_LATENCY];

    // Byte address bits 1 and 0 select a lane, so the word index starts at bit 2.
    assign word_idx = addr_i[RAM_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < XLEN/8; i++) begin
                if (be_i[i]) begin
                    mem[word_idx][i] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    // The word is sampled when the read is issued and then travels down the delay line.
    always_ff @(posedge clk) begin
        if (re_i) begin
            data_pipe[0] <= mem[word_idx];
        end
        for (int i = 1; i < LOAD_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ok_pipe <= '0;
        end else begin
            ok_pipe[0] <= re_i;
            for (int i = 1; i < LOAD_LATENCY; i++) begin
                ok_pipe[i] <= ok_pipe[i-1];
            end
        end
    end

    assign rdata_o   = data_pipe[LOAD_LATENCY-1];
    assign data_ok_o = ok_pipe[LOAD_LATENCY-1];

endmodule

//--- source/load_align_stage.sv
`timescale 1ns/1ps

module load_align_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                en_i,
    input  logic                                clr_i,
    input  logic                                s1_valid_i,
    input  logic [mem_op_pkg::OP_W-1:0]         s1_op_i,
    input  logic [mem_op_pkg::XLEN-1:0]         s1_addr_i,
    input  logic [mem_op_pkg::XLEN-1:0]         s1_wdata_i,
    input  logic [mem_op_pkg::REG_ADDR_W-1:0]   s1_waddr_i,
    input  logic                                s1_wreg_i,
    input  logic                                s1_excp_i,
    input  logic                                data_ok_i,
    input  logic [mem_op_pkg::XLEN-1:0]         rdata_i,
    output logic                                fwd_is_load_o,
    output logic                                fwd_data_ok_o,
    output logic                                fwd_wreg_o,
    output logic [mem_op_pkg::REG_ADDR_W-1:0]   fwd_waddr_o,
    output logic [mem_op_pkg::XLEN-1:0]         fwd_wdata_o,
    output logic                                wb_valid_o,
    output logic                                wb_wreg_o,
    output logic [mem_op_pkg::REG_ADDR_W-1:0]   wb_waddr_o,
    output logic [mem_op_pkg::XLEN-1:0]         wb_wdata_o,
    output logic                                wb_excp_o
);
    import mem_op_pkg::*;

    mem_word_u       ld_word;
    logic [7:0]      byte_sel;
    logic [15:0]     half_sel;
    logic            load_done;
    logic [XLEN-1:0] result;

    assign ld_word = rdata_i;

    // Address bits 1 and 0 index the lane within the returned word.
    assign byte_sel = ld_word.byte_lane[s1_addr_i[1:0]];
    assign half_sel = ld_word.half_lane[s1_addr_i[1]];

    assign load_done = fwd_is_load_o & data_ok_i & ~s1_excp_i;

    always_comb begin
        result = s1_wdata_i;
        if (load_done) begin
            case (s1_op_i)
                OP_LD_B:  result = {{(XLEN-8){byte_sel[7]}}, byte_sel};
                OP_LD_BU: result = {{(XLEN-8){1'b0}}, byte_sel};
                OP_LD_H:  result = {{(XLEN-16){half_sel[15]}}, half_sel};
                OP_LD_HU: result = {{(XLEN-16){1'b0}}, half_sel};
                OP_LD_W:  result = ld_word;
                default:  result = s1_wdata_i;
            endcase
        end
    end

    // The forwarding bundle lets earlier stages see a result before it is registered.
    assign fwd_is_load_o = s1_valid_i & op_is_load(s1_op_i);
    assign fwd_data_ok_o = data_ok_i;
    assign fwd_wreg_o    = s1_valid_i & s1_wreg_i;
    assign fwd_waddr_o   = s1_waddr_i;
    assign fwd_wdata_o   = result;

    // A held result stays on the wb outputs, but wb_valid_o pulses once per operation.
    always_ff @(posedge clk) begin
        if (rst || clr_i) begin
            wb_valid_o <= 1'b0;
            wb_wreg_o  <= 1'b0;
            wb_excp_o  <= 1'b0;
        end else begin
            wb_valid_o <= en_i & s1_valid_i;
            if (en_i) begin
                wb_wreg_o <= s1_wreg_i;
                wb_excp_o <= s1_excp_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            wb_waddr_o <= s1_waddr_i;
            wb_wdata_o <= result;
        end
    end

endmodule

//--- source/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid_i,
    input  logic [mem_op_pkg::OP_W-1:0]         op_i,
    input  logic [mem_op_pkg::XLEN-1:0]         addr_i,
    input  logic [mem_op_pkg::XLEN-1:0]         wdata_i,
    input  logic [mem_op_pkg::REG_ADDR_W-1:0]   waddr_i,
    input  logic                                wreg_i,
    input  logic                                flush_i,
    output logic                                ready_o,
    output logic                                fwd_is_load_o,
    output logic                                fwd_data_ok_o,
    output logic                                fwd_wreg_o,
    output logic [mem_op_pkg::REG_ADDR_W-1:0]   fwd_waddr_o,
    output logic [mem_op_pkg::XLEN-1:0]         fwd_wdata_o,
    output logic                                wb_valid_o,
    output logic                                wb_wreg_o,
    output logic [mem_op_pkg::REG_ADDR_W-1:0]   wb_waddr_o,
    output logic [mem_op_pkg::XLEN-1:0]         wb_wdata_o,
    output logic                                wb_excp_o
);
    import mem_op_pkg::*;

    logic                  s1_en;
    logic                  s1_clr;
    logic                  s2_en;
    logic                  s2_clr;
    logic                  s1_valid;
    logic [OP_W-1:0]       s1_op;
    logic [XLEN-1:0]       s1_addr;
    logic [XLEN-1:0]       s1_wdata;
    logic [REG_ADDR_W-1:0] s1_waddr;
    logic                  s1_wreg;
    logic                  s1_excp;
    logic                  s1_load_pending;
    logic                  ram_re;
    logic                  ram_we;
    logic [XLEN/8-1:0]     ram_be;
    logic [XLEN-1:0]       ram_addr;
    logic [XLEN-1:0]       ram_wdata;
    logic [XLEN-1:0]       ram_rdata;
    logic                  data_ok;

    mem_ctrl u_mem_ctrl (
        .clk               (clk),
        .rst               (rst),
        .valid_i           (valid_i),
        .flush_i           (flush_i),
        .s1_valid_i        (s1_valid),
        .s1_load_pending_i (s1_load_pending),
        .data_ok_i         (data_ok),
        .ready_o           (ready_o),
        .s1_en_o           (s1_en),
        .s1_clr_o          (s1_clr),
        .s2_en_o           (s2_en),
        .s2_clr_o          (s2_clr)
    );

    mem_addr_stage u_mem_addr_stage (
        .clk               (clk),
        .rst               (rst),
        .en_i              (s1_en),
        .clr_i             (s1_clr),
        .valid_i           (valid_i),
        .op_i              (op_i),
        .addr_i            (addr_i),
        .wdata_i           (wdata_i),
        .waddr_i           (waddr_i),
        .wreg_i            (wreg_i),
        .s1_valid_o        (s1_valid),
        .s1_op_o           (s1_op),
        .s1_addr_o         (s1_addr),
        .s1_wdata_o        (s1_wdata),
        .s1_waddr_o        (s1_waddr),
        .s1_wreg_o         (s1_wreg),
        .s1_excp_o         (s1_excp),
        .s1_load_pending_o (s1_load_pending),
        .ram_re_o          (ram_re),
        .ram_we_o          (ram_we),
        .ram_be_o          (ram_be),
        .ram_addr_o        (ram_addr),
        .ram_wdata_o       (ram_wdata)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .rst       (rst),
        .re_i      (ram_re),
        .we_i      (ram_we),
        .be_i      (ram_be),
        .addr_i    (ram_addr),
        .wdata_i   (ram_wdata),
        .rdata_o   (ram_rdata),
        .data_ok_o (data_ok)
    );

    load_align_stage u_load_align_stage (
        .clk           (clk),
        .rst           (rst),
        .en_i          (s2_en),
        .clr_i         (s2_clr),
        .s1_valid_i    (s1_valid),
        .s1_op_i       (s1_op),
        .s1_addr_i     (s1_addr),
        .s1_wdata_i    (s1_wdata),
        .s1_waddr_i    (s1_waddr),
        .s1_wreg_i     (s1_wreg),
        .s1_excp_i     (s1_excp),
        .data_ok_i     (data_ok),
        .rdata_i       (ram_rdata),
        .fwd_is_load_o (fwd_is_load_o),
        .fwd_data_ok_o (fwd_data_ok_o),
        .fwd_wreg_o    (fwd_wreg_o),
        .fwd_waddr_o   (fwd_waddr_o),
        .fwd_wdata_o   (fwd_wdata_o),
        .wb_valid_o    (wb_valid_o),
        .wb_wreg_o     (wb_wreg_o),
        .wb_waddr_o    (wb_waddr_o),
        .wb_wdata_o    (wb_wdata_o),
        .wb_excp_o     (wb_excp_o)
    );

endmodule

//--- verification/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;
    import mem_op_pkg::*;
    import mem_cfg_pkg::*;

    localparam int MAX_OPS = 64;
    localparam int N_TESTS = 6;

    logic                  clk;
    logic                  rst;
    logic                  valid_i;
    logic [OP_W-1:0]       op_i;
    logic [XLEN-1:0]       addr_i;
    logic [XLEN-1:0]       wdata_i;
    logic [REG_ADDR_W-1:0] waddr_i;
    logic                  wreg_i;
    logic                  flush_i;
    logic                  ready_o;
    logic                  fwd_is_load_o;
    logic                  fwd_data_ok_o;
    logic                  fwd_wreg_o;
    logic [REG_ADDR_W-1:0] fwd_waddr_o;
    logic [XLEN-1:0]       fwd_wdata_o;
    logic                  wb_valid_o;
    logic                  wb_wreg_o;
    logic [REG_ADDR_W-1:0] wb_waddr_o;
    logic [XLEN-1:0]       wb_wdata_o;
    logic                  wb_excp_o;

    int                    line_test [MAX_OPS];
    logic [OP_W-1:0]       line_op [MAX_OPS];
    logic [XLEN-1:0]       line_addr [MAX_OPS];
    logic [XLEN-1:0]       line_data [MAX_OPS];
    logic [REG_ADDR_W-1:0] line_reg [MAX_OPS];
    logic                  line_wreg [MAX_OPS];
    logic                  line_flush [MAX_OPS];
    logic [XLEN-1:0]       line_exp [MAX_OPS];
    logic [XLEN-1:0]       model_data [MAX_OPS];
    logic                  model_excp [MAX_OPS];
    logic [7:0]            model_mem [1024];

    // Results still owed by the DUT, oldest first.
    logic [XLEN-1:0]       q_data [$];
    logic [REG_ADDR_W-1:0] q_waddr [$];
    logic                  q_wreg [$];
    logic                  q_excp [$];

    int n_ops;
    int cycle_cnt;
    int cycle_limit;
    int pass_cnt;
    int fail_cnt;
    int cur_test;
    int test_fail [N_TESTS+1];
    int test_ops [N_TESTS+1];
    int fwd_hits [N_TESTS+1];

    mem_subsys u_mem_subsys (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (valid_i),
        .op_i          (op_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .waddr_i       (waddr_i),
        .wreg_i        (wreg_i),
        .flush_i       (flush_i),
        .ready_o       (ready_o),
        .fwd_is_load_o (fwd_is_load_o),
        .fwd_data_ok_o (fwd_data_ok_o),
        .fwd_wreg_o    (fwd_wreg_o),
        .fwd_waddr_o   (fwd_waddr_o),
        .fwd_wdata_o   (fwd_wdata_o),
        .wb_valid_o    (wb_valid_o),
        .wb_wreg_o     (wb_wreg_o),
        .wb_waddr_o    (wb_waddr_o),
        .wb_wdata_o    (wb_wdata_o),
        .wb_excp_o     (wb_excp_o)
    );

    always #20 clk = ~clk;

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) begin
            pass_cnt++;
        end else begin
            $display("[FAIL] test %0d %s expected 0x%08h got 0x%08h", cur_test, name, exp, act);
            fail_cnt++;
            test_fail[cur_test]++;
        end
    endtask

    task automatic check_true(input int test, input logic ok, input string msg);
        assert (ok) else begin
            $display("test %0d: %s", test, msg);
            fail_cnt++;
            test_fail[test]++;
        end
    endtask

    task automatic read_stimulus();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f_test;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_reg;
        logic [31:0] f_wreg;
        logic [31:0] f_flush;
        logic [31:0] f_exp;
        fd = $fopen("verification/mem_stim.txt", "r");
        n_ops = 0;
        check_true(0, fd != 0, "the stimulus file could not be opened");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h", f_test, f_op, f_addr,
                                   f_data, f_reg, f_wreg, f_flush, f_exp);
                    if (code == 8 && n_ops < MAX_OPS) begin
                        line_test[n_ops]  = int'(f_test);
                        line_op[n_ops]    = f_op[OP_W-1:0];
                        line_addr[n_ops]  = f_addr;
                        line_data[n_ops]  = f_data;
                        line_reg[n_ops]   = f_reg[REG_ADDR_W-1:0];
                        line_wreg[n_ops]  = f_wreg[0];
                        line_flush[n_ops] = f_flush[0];
                        line_exp[n_ops]   = f_exp;
                        n_ops++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Byte-array model in little-endian order; flushed lines in the file are loads only.
    task automatic build_model();
        logic [9:0]  ba;
        logic [31:0] d;
        logic [31:0] w;
        logic        ex;
        for (int i = 0; i < n_ops; i++) begin
            ba = line_addr[i][9:0];
            d  = line_data[i];
            ex = 1'b0;
            w  = {model_mem[ba + 10'd3], model_mem[ba + 10'd2],
                  model_mem[ba + 10'd1], model_mem[ba]};
            case (line_op[i])
                OP_LD_B:  d = {{24{w[7]}}, w[7:0]};
                OP_LD_BU: d = {24'd0, w[7:0]};
                OP_LD_H:  ex = ba[0];
                OP_LD_HU: ex = ba[0];
                OP_LD_W:  ex = |ba[1:0];
                OP_ST_H:  ex = ba[0];
                OP_ST_W:  ex = |ba[1:0];
                default:  ex = 1'b0;
            endcase
            if (!ex) begin
                case (line_op[i])
                    OP_LD_H:  d = {{16{w[15]}}, w[15:0]};
                    OP_LD_HU: d = {16'd0, w[15:0]};
                    OP_LD_W:  d = w;
                    OP_ST_B:  model_mem[ba] = line_data[i][7:0];
                    OP_ST_H: begin
                        model_mem[ba]         = line_data[i][7:0];
                        model_mem[ba + 10'd1] = line_data[i][15:8];
                    end
                    OP_ST_W: begin
                        for (int b = 0; b < 4; b++) begin
                            model_mem[ba + 10'(b)] = line_data[i][8*b +: 8];
                        end
                    end
                    default: ;
                endcase
            end
            model_data[i] = d;
            model_excp[i] = ex;
            if (!line_flush[i]) begin
                check_true(line_test[i], d === line_exp[i],
                           "a stimulus line disagrees with the reference model");
            end
        end
    endtask

    task automatic send_op(input int i);
        @(negedge clk);
        valid_i = 1'b1;
        flush_i = 1'b0;
        op_i    = line_op[i];
        addr_i  = line_addr[i];
        wdata_i = line_data[i];
        waddr_i = line_reg[i];
        wreg_i  = line_wreg[i];
        // ready_o depends only on state, so its value now holds for the next edge.
        while (ready_o !== 1'b1) @(negedge clk);
        q_data.push_back(model_data[i]);
        q_waddr.push_back(line_reg[i]);
        q_wreg.push_back(line_wreg[i]);
        q_excp.push_back(model_excp[i]);
        test_ops[cur_test]++;
    endtask

    task automatic send_flush();
        @(negedge clk);
        valid_i = 1'b0;
        flush_i = 1'b1;
        op_i    = OP_NONE;
    endtask

    task automatic drain();
        @(negedge clk);
        valid_i = 1'b0;
        flush_i = 1'b0;
        while (q_data.size() != 0) @(negedge clk);
    endtask

    task automatic finish_test(input int t);
        if (t == N_TESTS) begin
            check_true(t, fwd_hits[t] != 0, "no forwarded load data was seen");
        end
        $display("test %0d: %0d operations, %0d failures, %s", t, test_ops[t], test_fail[t],
                 (test_fail[t] == 0) ? "ok" : "failed");
    endtask

    // Outputs are sampled on the falling edge, half a cycle away from any update.
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_valid_o) begin
                check_true(cur_test, q_data.size() != 0,
                           "wb_valid_o pulsed with no operation in flight");
                if (q_data.size() != 0) begin
                    check_word("wb_wdata_o", q_data[0], wb_wdata_o);
                    check_word("wb_waddr_o", 32'(q_waddr[0]), 32'(wb_waddr_o));
                    check_word("wb_wreg_o", 32'(q_wreg[0]), 32'(wb_wreg_o));
                    check_word("wb_excp_o", 32'(q_excp[0]), 32'(wb_excp_o));
                    void'(q_data.pop_front());
                    void'(q_waddr.pop_front());
                    void'(q_wreg.pop_front());
                    void'(q_excp.pop_front());
                end
            end
            if (fwd_is_load_o && q_data.size() != 0) begin
                check_word("fwd_waddr_o", 32'(q_waddr[0]), 32'(fwd_waddr_o));
                check_word("fwd_wreg_o", 32'(q_wreg[0]), 32'(fwd_wreg_o));
                if (!q_excp[0]) begin
                    if (fwd_data_ok_o) begin
                        check_word("fwd_wdata_o", q_data[0], fwd_wdata_o);
                        fwd_hits[cur_test]++;
                    end else begin
                        check_word("ready_o", 32'd0, 32'(ready_o));
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        if (flush_i && !rst) begin
            q_data.delete();
            q_waddr.delete();
            q_wreg.delete();
            q_excp.delete();
        end
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("The run timed out after %0d cycles.", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        valid_i     = 1'b0;
        flush_i     = 1'b0;
        op_i        = OP_NONE;
        addr_i      = '0;
        wdata_i     = '0;
        waddr_i     = '0;
        wreg_i      = 1'b0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        cur_test    = 0;
        for (int t = 0; t <= N_TESTS; t++) begin
            test_fail[t] = 0;
            test_ops[t]  = 0;
            fwd_hits[t]  = 0;
        end
        read_stimulus();
        build_model();
        cycle_limit = n_ops * (LOAD_LATENCY + 3) + 50;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cur_test = line_test[0];
        for (int i = 0; i < n_ops; i++) begin
            if (line_test[i] != cur_test) begin
                drain();
                finish_test(cur_test);
                cur_test = line_test[i];
            end
            if (line_flush[i]) begin
                send_flush();
            end else begin
                send_op(i);
            end
        end
        drain();
        finish_test(cur_test);
        $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verification/mem_stim.txt
# test op addr data reg wreg flush expected  (all hex, one operation per line)
# op: 0 pass, 1 lb, 2 lbu, 3 lh, 4 lhu, 5 lw, 6 sb, 7 sh, 8 sw; flush 1 drops what is in flight
1 8 00000010 11223344 01 1 0 11223344
1 8 00000014 a5a5f00f 02 1 0 a5a5f00f
1 5 00000010 00000000 03 1 0 11223344
1 5 00000014 00000000 04 1 0 a5a5f00f
1 0 00000000 cafebabe 05 1 0 cafebabe
2 8 00000020 00000000 00 0 0 00000000
2 6 00000021 000000f7 00 0 0 000000f7
2 6 00000023 00000080 00 0 0 00000080
2 8 00000024 12345678 00 0 0 12345678
2 7 00000026 0000beef 00 0 0 0000beef
2 5 00000020 00000000 06 1 0 8000f700
2 1 00000021 00000000 07 1 0 fffffff7
2 2 00000021 00000000 08 1 0 000000f7
2 1 00000023 00000000 09 1 0 ffffff80
2 2 00000020 00000000 0a 1 0 00000000
2 3 00000026 00000000 0b 1 0 ffffbeef
2 4 00000026 00000000 0c 1 0 0000beef
2 3 00000024 00000000 0d 1 0 00005678
2 5 00000024 00000000 0e 1 0 beef5678
3 5 00000011 00000000 0f 1 0 00000000
3 8 00000012 deadbeef 00 0 0 deadbeef
3 7 00000013 0000ffff 00 0 0 0000ffff
3 3 00000015 00000000 10 1 0 00000000
3 5 00000010 00000000 11 1 0 11223344
4 5 00000014 00000000 13 1 0 a5a5f00f
4 0 00000000 00000001 14 1 0 00000001
4 2 00000017 00000000 15 1 0 000000a5
4 1 00000016 00000000 16 1 0 ffffffa5
4 5 00000020 00000000 17 1 0 8000f700
5 5 00000010 00000000 18 1 0 11223344
5 0 00000000 00000000 00 0 1 00000000
5 5 00000024 00000000 19 1 0 beef5678
5 0 00000000 12121212 1a 1 0 12121212
6 5 00000010 00000000 1b 1 0 11223344
6 4 00000014 00000000 1c 1 0 0000f00f
6 2 00000014 00000000 1d 1 0 0000000f
6 0 00000000 55aa55aa 1e 0 0 55aa55aa

//--- tb.f
source/mem_op_pkg.sv
source/mem_cfg_pkg.sv
source/mem_ctrl.sv
source/mem_addr_stage.sv
source/data_ram.sv
source/load_align_stage.sv
source/mem_subsys.sv
verification/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module mem_subsys_tb -o mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status."
    exit 1
fi

./obj_dir/mem_subsys_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
    echo "Simulation passed."
    exit 0
else
    echo "Simulation failed."
    exit 1
fi
